//--- bnn_settings.svh
`ifndef BNN_SETTINGS_SVH
`define BNN_SETTINGS_SVH

//////////////////////////////////////////////////
// Network sizes
//////////////////////////////////////////////////

`define BNN_FEAT_CNT   4 // Features per input vector.
`define BNN_FEAT_BITS  4 // Unsigned feature width.
`define BNN_HIDDEN_CNT 8 // First layer neurons.
`define BNN_CLASS_CNT  4 // Output classes.

//////////////////////////////////////////////////
// Constant weight tables
//////////////////////////////////////////////////

// A weight bit of 1 stands for +1, a 0 for -1.

// Hidden layer, one row of BNN_FEAT_CNT bits per neuron.
// Neuron j uses bits j*4 +: 4, with feature 0 in the low bit.
// Rows from neuron 7 down to neuron 0.
`define BNN_HIDDEN_WEIGHTS 32'h6A3C_95E1

// Output layer, one row of BNN_HIDDEN_CNT bits per class.
// Class k uses bits k*8 +: 8, with hidden bit 0 in the low bit.
// Class 0 and 1 are complements, as are class 2 and 3.
`define BNN_OUTPUT_WEIGHTS 32'hF00F_3CC3

`endif

//--- bnn_pkg.sv
`include "bnn_settings.svh"
`default_nettype none

package bnn_pkg;

  //////////////////////////////////////////////////
  // Vector types
  //////////////////////////////////////////////////

  typedef logic [`BNN_FEAT_BITS-1:0] feature_t;

  // Feature 0 in the lowest slice.
  typedef logic [`BNN_FEAT_CNT*`BNN_FEAT_BITS-1:0] feature_vec_t;

  // Neuron 0 at bit 0.
  typedef logic [`BNN_HIDDEN_CNT-1:0] hidden_vec_t;

  // Shift sequencer state, enough for the idle state plus one per neuron.
  typedef logic [$clog2(`BNN_HIDDEN_CNT + 1)-1:0] seq_state_t;

  typedef logic [$clog2(`BNN_HIDDEN_CNT + 1)-1:0] score_t; // 0 to HIDDEN_CNT.

  typedef logic [$clog2(`BNN_CLASS_CNT)-1:0] class_idx_t;

  // Class 0 in the lowest slice.
  typedef logic [`BNN_CLASS_CNT*$bits(score_t)-1:0] score_vec_t;

  //////////////////////////////////////////////////
  // Control and result
  //////////////////////////////////////////////////

  typedef enum logic {
    st_idle,
    st_run
  } layer_state_t;

  typedef struct packed {
    class_idx_t class_idx;
    score_t     best_score;
  } bnn_result_t;

endpackage

`default_nettype wire

//--- bnn_hidden_layer.sv
`include "bnn_settings.svh"
`default_nettype none

module bnn_hidden_layer (
  input  wire                          clk,
  input  wire                          rst,
  input  wire logic                    start,
  input  wire bnn_pkg::feature_vec_t   features,
  output logic                         busy,
  output bnn_pkg::hidden_vec_t         hidden,
  output logic                         hidden_valid
);
  import bnn_pkg::*;

  localparam int FEAT_CNT   = `BNN_FEAT_CNT;
  localparam int FEAT_BITS  = `BNN_FEAT_BITS;
  localparam int HIDDEN_CNT = `BNN_HIDDEN_CNT;
  localparam int SEQ_BITS   = $bits(seq_state_t);
  localparam int SEQ_STATES = 2 ** SEQ_BITS;
  localparam int NEG_BITS   = $clog2(FEAT_CNT + 1);
  localparam int SUM_BITS   = FEAT_BITS + $clog2(FEAT_CNT) + 2;

  localparam logic [HIDDEN_CNT*FEAT_CNT-1:0] HIDDEN_W = `BNN_HIDDEN_WEIGHTS;

  //////////////////////////////////////////////////
  // Sequencer and weight tables
  //////////////////////////////////////////////////

  function automatic seq_state_t seq_step(input seq_state_t s);
    return {s[SEQ_BITS-2:0], s[SEQ_BITS-1] ~^ s[SEQ_BITS-2]}; // XNOR feedback.
  endfunction

  function automatic seq_state_t seq_after(input int n);
    seq_state_t s;
    s = '0;
    for (int i = 0; i < n; i++) begin
      s = seq_step(s);
    end
    return s;
  endfunction

  // Row j goes to the state the sequencer holds while evaluating neuron j.
  function automatic logic [SEQ_STATES*FEAT_CNT-1:0] build_rows();
    logic [SEQ_STATES*FEAT_CNT-1:0] t;
    t = '0;
    for (int j = 0; j < HIDDEN_CNT; j++) begin
      t[seq_after(j)*FEAT_CNT +: FEAT_CNT] = HIDDEN_W[j*FEAT_CNT +: FEAT_CNT];
    end
    return t;
  endfunction

  localparam logic [SEQ_STATES*FEAT_CNT-1:0] ROW_TABLE = build_rows();

  function automatic logic [SEQ_STATES*NEG_BITS-1:0] build_negs();
    logic [SEQ_STATES*NEG_BITS-1:0] t;
    logic [NEG_BITS-1:0]            n;
    t = '0;
    for (int s = 0; s < SEQ_STATES; s++) begin
      n = '0;
      for (int i = 0; i < FEAT_CNT; i++) begin
        n = n + NEG_BITS'(!ROW_TABLE[s*FEAT_CNT + i]);
      end
      t[s*NEG_BITS +: NEG_BITS] = n;
    end
    return t;
  endfunction

  localparam logic [SEQ_STATES*NEG_BITS-1:0] NEG_TABLE = build_negs();

  localparam seq_state_t SEQ_LAST = seq_after(HIDDEN_CNT); // Terminal state.

  layer_state_t               state;
  seq_state_t                 seq;
  seq_state_t                 seq_next;
  feature_vec_t               feat_q;
  hidden_vec_t                hid_shift;
  logic [FEAT_CNT-1:0]        row;
  logic [NEG_BITS-1:0]        neg_cnt;
  logic signed [SUM_BITS-1:0] sum;
  logic                       neuron_bit;
  logic                       last_step;
  logic                       accept;

  assign row       = ROW_TABLE[seq*FEAT_CNT +: FEAT_CNT];
  assign neg_cnt   = NEG_TABLE[seq*NEG_BITS +: NEG_BITS];
  assign seq_next  = seq_step(seq);
  assign last_step = (seq_next == SEQ_LAST);
  assign busy      = (state == st_run);
  assign accept    = start && (state == st_idle);

  //////////////////////////////////////////////////
  // Neuron sum
  //////////////////////////////////////////////////

  always_comb begin
    feature_t                   f;
    logic signed [SUM_BITS-1:0] term;
    sum = SUM_BITS'(neg_cnt); // Corrects the ones-complement terms.
    for (int i = 0; i < FEAT_CNT; i++) begin
      f    = feat_q[i*FEAT_BITS +: FEAT_BITS];
      term = row[i] ? SUM_BITS'(f) : ~SUM_BITS'(f);
      sum  = sum + term;
    end
  end

  assign neuron_bit = (sum >= 0);

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state        <= st_idle;
      seq          <= '0;
      hidden       <= '0;
      hidden_valid <= 1'b0;
    end else begin
      hidden_valid <= 1'b0;
      case (state)
        st_idle: begin
          if (start) begin
            state <= st_run;
            seq   <= '0;
          end
        end
        st_run: begin
          seq <= seq_next;
          if (last_step) begin
            state        <= st_idle;
            hidden       <= {neuron_bit, hid_shift[HIDDEN_CNT-1:1]};
            hidden_valid <= 1'b1;
          end
        end
        default: state <= st_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      feat_q <= features;
    end
    if (busy) begin
      hid_shift <= {neuron_bit, hid_shift[HIDDEN_CNT-1:1]}; // Enters at the top.
    end
  end

endmodule

`default_nettype wire

//--- bnn_output_layer.sv
`include "bnn_settings.svh"
`default_nettype none

module bnn_output_layer (
  input  wire                        clk,
  input  wire                        rst,
  input  wire bnn_pkg::hidden_vec_t  hidden,
  input  wire logic                  hidden_valid,
  output bnn_pkg::score_vec_t        scores,
  output logic                       scores_valid
);
  import bnn_pkg::*;

  localparam int HIDDEN_CNT = `BNN_HIDDEN_CNT;
  localparam int CLASS_CNT  = `BNN_CLASS_CNT;
  localparam int SCORE_BITS = $bits(score_t);

  localparam logic [CLASS_CNT*HIDDEN_CNT-1:0] OUTPUT_W = `BNN_OUTPUT_WEIGHTS;

  //////////////////////////////////////////////////
  // XNOR popcount per class
  //////////////////////////////////////////////////

  score_vec_t score_d;

  always_comb begin
    score_t cnt;
    score_d = '0;
    for (int k = 0; k < CLASS_CNT; k++) begin
      cnt = '0;
      for (int h = 0; h < HIDDEN_CNT; h++) begin
        // Agreement between hidden bit and weight bit.
        cnt = cnt + SCORE_BITS'(hidden[h] ~^ OUTPUT_W[k*HIDDEN_CNT + h]);
      end
      score_d[k*SCORE_BITS +: SCORE_BITS] = cnt;
    end
  end

  //////////////////////////////////////////////////
  // Score register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      scores       <= '0;
      scores_valid <= 1'b0;
    end else begin
      scores_valid <= hidden_valid; // One cycle behind the hidden vector.
      if (hidden_valid) begin
        scores <= score_d;
      end
    end
  end

endmodule

`default_nettype wire

//--- bnn_argmax.sv
`include "bnn_settings.svh"
`default_nettype none

module bnn_argmax (
  input  wire                       clk,
  input  wire                       rst,
  input  wire bnn_pkg::score_vec_t  scores,
  input  wire logic                 scores_valid,
  output bnn_pkg::bnn_result_t      result,
  output logic                      result_valid
);
  import bnn_pkg::*;

  localparam int CLASS_CNT  = `BNN_CLASS_CNT;
  localparam int SCORE_BITS = $bits(score_t);

  bnn_result_t best;

  // Strictly greater wins, so ties stay with the lower class.
  always_comb begin
    score_t s;
    best.class_idx  = '0;
    best.best_score = scores[SCORE_BITS-1:0];
    for (int k = 1; k < CLASS_CNT; k++) begin
      s = scores[k*SCORE_BITS +: SCORE_BITS];
      if (s > best.best_score) begin
        best.class_idx  = class_idx_t'(k);
        best.best_score = s;
      end
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      result       <= '0;
      result_valid <= 1'b0;
    end else begin
      result_valid <= scores_valid;
      if (scores_valid) begin
        result <= best; // Held until the next item.
      end
    end
  end

endmodule

`default_nettype wire

//--- bnn_classifier.sv
`default_nettype none

module bnn_classifier (
  input  wire                         clk,
  input  wire                         rst,
  input  wire logic                   start,
  input  wire bnn_pkg::feature_vec_t  features,
  output wire logic                   busy,
  output wire bnn_pkg::hidden_vec_t   hidden,
  output wire logic                   hidden_valid,
  output wire bnn_pkg::bnn_result_t   result,
  output wire logic                   result_valid
);
  import bnn_pkg::*;

  //////////////////////////////////////////////////
  // Pipeline stages
  //////////////////////////////////////////////////

  score_vec_t scores;
  logic       scores_valid;

  // Sequential first layer, one neuron per clock.
  bnn_hidden_layer u_hidden (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .features     (features),
    .busy         (busy),
    .hidden       (hidden),
    .hidden_valid (hidden_valid)
  );

  bnn_output_layer u_output (
    .clk          (clk),
    .rst          (rst),
    .hidden       (hidden),
    .hidden_valid (hidden_valid),
    .scores       (scores),
    .scores_valid (scores_valid)
  );

  bnn_argmax u_argmax (
    .clk          (clk),
    .rst          (rst),
    .scores       (scores),
    .scores_valid (scores_valid),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

`default_nettype wire

//--- tb_bnn_model.svh
`ifndef TB_BNN_MODEL_SVH
`define TB_BNN_MODEL_SVH

//////////////////////////////////////////////////
// Reference model of the classifier
//////////////////////////////////////////////////

// Exact signed sum of hidden neuron j.
function automatic int neuron_sum(input feature_vec_t f, input int j);
  logic [`BNN_HIDDEN_CNT*`BNN_FEAT_CNT-1:0] w;
  int                                       sum;
  int                                       x;
  w   = `BNN_HIDDEN_WEIGHTS;
  sum = 0;
  for (int i = 0; i < `BNN_FEAT_CNT; i++) begin
    x = int'(f[i*`BNN_FEAT_BITS +: `BNN_FEAT_BITS]);
    if (w[j*`BNN_FEAT_CNT + i]) begin
      sum = sum + x; // Weight +1.
    end else begin
      sum = sum - x; // Weight -1.
    end
  end
  return sum;
endfunction

function automatic hidden_vec_t model_hidden(input feature_vec_t f);
  hidden_vec_t h;
  h = '0;
  for (int j = 0; j < `BNN_HIDDEN_CNT; j++) begin
    h[j] = (neuron_sum(f, j) >= 0); // Zero counts as active.
  end
  return h;
endfunction

// Agreeing bits between the hidden vector and row k.
function automatic int class_score(input hidden_vec_t h, input int k);
  logic [`BNN_CLASS_CNT*`BNN_HIDDEN_CNT-1:0] w;
  int                                        n;
  w = `BNN_OUTPUT_WEIGHTS;
  n = 0;
  for (int i = 0; i < `BNN_HIDDEN_CNT; i++) begin
    if (h[i] == w[k*`BNN_HIDDEN_CNT + i]) begin
      n++;
    end
  end
  return n;
endfunction

function automatic int top_score(input hidden_vec_t h);
  int best;
  best = 0;
  for (int k = 0; k < `BNN_CLASS_CNT; k++) begin
    if (class_score(h, k) > best) begin
      best = class_score(h, k);
    end
  end
  return best;
endfunction

// Lowest class index that reaches the top score.
function automatic bnn_result_t model_result(input hidden_vec_t h);
  bnn_result_t r;
  r = '0;
  for (int k = `BNN_CLASS_CNT - 1; k >= 0; k--) begin
    if (class_score(h, k) == top_score(h)) begin
      r.class_idx = class_idx_t'(k);
    end
  end
  r.best_score = score_t'(top_score(h));
  return r;
endfunction

function automatic int top_class_count(input hidden_vec_t h);
  int n;
  n = 0;
  for (int k = 0; k < `BNN_CLASS_CNT; k++) begin
    if (class_score(h, k) == top_score(h)) begin
      n++;
    end
  end
  return n;
endfunction

`endif

//--- tb_bnn_classifier.sv
`include "bnn_settings.svh"
`default_nettype none

module tb_bnn_classifier;
  import bnn_pkg::*;

  `include "tb_bnn_model.svh"

  localparam int RESET_CYCLES = 8;
  localparam int RANDOM_CNT   = 200;
  localparam int ITEM_CNT     = 3 + 2 + 3 + RANDOM_CNT + 1; // Start pulses driven.
  localparam int CYCLE_LIMIT  = 40 * ITEM_CNT + 100;
  localparam int HIDDEN_CNT   = `BNN_HIDDEN_CNT;
  localparam int LATENCY      = HIDDEN_CNT + 2; // Accepted start to result_valid.

  logic         clk;
  logic         rst;
  logic         start;
  feature_vec_t features;
  logic         busy;
  hidden_vec_t  hidden;
  logic         hidden_valid;
  bnn_result_t  result;
  logic         result_valid;

  hidden_vec_t  exp_hidden [ITEM_CNT];
  bnn_result_t  exp_result [ITEM_CNT];
  int           issued = 0;
  int           chk_errs = 0;
  int           test_cnt = 0;
  int           test_ok = 0;
  int           seed;
  int           hid_idx = 0;
  int           res_idx = 0;
  int           mon_errs = 0;
  int           result_pulses = 0;
  bnn_result_t  last_result;
  int           cycle_cnt = 0;

  bnn_classifier UUT (
    .clk          (clk),
    .rst          (rst),
    .start        (start),
    .features     (features),
    .busy         (busy),
    .hidden       (hidden),
    .hidden_valid (hidden_valid),
    .result       (result),
    .result_valid (result_valid)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d clock cycles", CYCLE_LIMIT);
      $display("tests failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Output monitor, in issue order
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    if (!rst && hidden_valid) begin
      if (hid_idx >= issued) begin
        $display("hidden_valid pulsed at time %0t with no item outstanding", $time);
        mon_errs++;
      end else begin
        if (hidden !== exp_hidden[hid_idx]) begin
          $display("error at time %0t: hidden = %0h, expected %0h",
                   $time, hidden, exp_hidden[hid_idx]);
          mon_errs++;
        end
        hid_idx++;
      end
    end
    if (!rst && result_valid) begin
      result_pulses++;
      last_result = result;
      if (res_idx >= issued) begin
        $display("result_valid pulsed at time %0t with no item outstanding", $time);
        mon_errs++;
      end else begin
        if (result !== exp_result[res_idx]) begin
          $display("error at time %0t: result = class %0d score %0d, expected class %0d score %0d",
                   $time, result.class_idx, result.best_score,
                   exp_result[res_idx].class_idx, exp_result[res_idx].best_score);
          mon_errs++;
        end
        res_idx++;
      end
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] want);
    if (got !== want) begin
      $display("error at time %0t: %s = %0h, expected %0h", $time, name, got, want);
      chk_errs++;
    end
  endtask

  task automatic wait_idle();
    while (busy) begin
      next_cycle();
    end
  endtask

  // One start pulse, with the expected outputs queued first.
  task automatic issue(input feature_vec_t f);
    hidden_vec_t h;
    h = model_hidden(f);
    exp_hidden[issued] = h;
    exp_result[issued] = model_result(h);
    issued++;
    start    = 1'b1;
    features = f;
    next_cycle();
    start = 1'b0;
  endtask

  task automatic drain();
    while (res_idx < issued) begin
      next_cycle();
    end
    repeat (LATENCY) next_cycle(); // Room for a stray pulse.
  endtask

  task automatic finish_test(input string name, input int errs_before);
    int errs;
    errs = chk_errs + mon_errs - errs_before;
    test_cnt++;
    if (errs == 0) begin
      test_ok++;
      $display("test %s: ok", name);
    end else begin
      $display("test %s: %0d errors", name, errs);
    end
  endtask

  task automatic check_outputs_idle();
    check_val("busy", 32'(busy), 32'd0);
    check_val("hidden_valid", 32'(hidden_valid), 32'd0);
    check_val("result_valid", 32'(result_valid), 32'd0);
    check_val("hidden", 32'(hidden), 32'd0);
    check_val("result", 32'(result), 32'd0);
  endtask

  // Feature vector whose top score is shared, or -1.
  function automatic int find_tie(input bit winner_above_0);
    hidden_vec_t h;
    bnn_result_t r;
    for (int c = 0; c < (1 << $bits(feature_vec_t)); c++) begin
      h = model_hidden(feature_vec_t'(c));
      r = model_result(h);
      if (top_class_count(h) >= 2 && (!winner_above_0 || r.class_idx != '0)) begin
        return c;
      end
    end
    return -1;
  endfunction

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    int e0;
    e0 = chk_errs + mon_errs;
    repeat (RESET_CYCLES / 2) next_cycle();
    check_outputs_idle();
    repeat (RESET_CYCLES - RESET_CYCLES / 2) next_cycle();
    rst = 1'b0;
    next_cycle();
    check_outputs_idle();
    finish_test("reset state", e0);
  endtask

  task automatic test_fixed();
    feature_vec_t vecs [3];
    int           e0;
    int           edges;
    e0 = chk_errs + mon_errs;
    vecs[0] = '0;
    vecs[1] = '1;
    vecs[2] = feature_vec_t'(16'hF0F0); // Zero and maximum in turn.
    for (int v = 0; v < 3; v++) begin
      wait_idle();
      issue(vecs[v]);
      edges = 0;
      while (!result_valid && edges < 4 * LATENCY) begin
        if (edges < HIDDEN_CNT) begin
          check_val("busy", 32'(busy), 32'd1);
        end
        next_cycle();
        edges++;
      end
      if (!result_valid) begin
        $display("result_valid did not arrive within %0d cycles of start", 4 * LATENCY);
        chk_errs++;
      end else begin
        check_val("result_valid latency", edges, LATENCY);
      end
      drain();
    end
    finish_test("fixed vectors", e0);
  endtask

  task automatic test_start_ignored();
    int e0;
    int p0;
    e0 = chk_errs + mon_errs;
    p0 = result_pulses;
    wait_idle();
    issue(feature_vec_t'(16'h37C1));
    repeat (3) next_cycle();
    check_val("busy", 32'(busy), 32'd1);
    start    = 1'b1; // Mid-run, must be dropped.
    features = feature_vec_t'(16'hC83E);
    next_cycle();
    start = 1'b0;
    drain();
    check_val("result_valid count", result_pulses - p0, 1);
    finish_test("start ignored while busy", e0);
  endtask

  task automatic test_back_to_back();
    feature_vec_t vecs [3];
    int           e0;
    int           p0;
    e0 = chk_errs + mon_errs;
    p0 = result_pulses;
    vecs[0] = feature_vec_t'(16'h1F2E);
    vecs[1] = feature_vec_t'(16'h8C07);
    vecs[2] = feature_vec_t'(16'h5AF3);
    wait_idle();
    for (int i = 0; i < 3; i++) begin
      if (i > 0) begin
        wait_idle();
        check_val("hidden_valid", 32'(hidden_valid), 32'd1); // Cycle busy falls.
      end
      issue(vecs[i]);
    end
    drain();
    check_val("result_valid count", result_pulses - p0, 3);
    finish_test("back-to-back items", e0);
  endtask

  task automatic test_random();
    int e0;
    e0 = chk_errs + mon_errs;
    for (int n = 0; n < RANDOM_CNT; n++) begin
      wait_idle();
      issue(feature_vec_t'($random(seed)));
    end
    drain();
    finish_test("random vectors", e0);
  endtask

  task automatic test_tie();
    int          e0;
    int          pick;
    bnn_result_t want;
    e0   = chk_errs + mon_errs;
    pick = find_tie(1'b1);
    if (pick < 0) begin
      pick = find_tie(1'b0);
    end
    if (pick < 0) begin
      $display("tie test setup: no feature vector gives two classes the same top score");
      chk_errs++;
    end else begin
      want = model_result(model_hidden(feature_vec_t'(pick)));
      wait_idle();
      issue(feature_vec_t'(pick));
      drain();
      check_val("result.class_idx", 32'(last_result.class_idx), 32'(want.class_idx));
    end
    finish_test("tie rule", e0);
  endtask

  initial begin
    clk      = 1'b0;
    rst      = 1'b1;
    start    = 1'b0;
    features = '0;
    seed     = 18;
    test_reset();
    test_fixed();
    test_start_ignored();
    test_back_to_back();
    test_random();
    test_tie();
    $display("summary: passed %0d of %0d tests, %0d check errors",
             test_ok, test_cnt, chk_errs + mon_errs);
    if (chk_errs + mon_errs == 0 && test_ok == test_cnt) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+.
bnn_pkg.sv
bnn_hidden_layer.sv
bnn_output_layer.sv
bnn_argmax.sv
bnn_classifier.sv
tb_bnn_classifier.sv

//--- Makefile
TOOL  = verilator
FLAGS = --binary --timing
TOP   = tb_bnn_classifier
FLIST = flist.f
PASS  = all tests passed

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS)"

clean:
	rm -rf obj_dir
